// ==== files.f ====
logic/bp_pkg.sv
logic/rv_isa_pkg.sv
logic/bp_update_if.sv
logic/gshare_predictor.sv
logic/jalr_predictor.sv
logic/jump_controller.sv
tests/jump_controller_assert.sv
tests/jump_controller_tb.sv

// ==== Bender.yml ====
package:
  name: jump_controller

sources:
  - logic/bp_pkg.sv
  - logic/rv_isa_pkg.sv
  - logic/bp_update_if.sv
  - logic/gshare_predictor.sv
  - logic/jalr_predictor.sv
  - logic/jump_controller.sv
  - target: test
    files:
      - tests/jump_controller_assert.sv
      - tests/jump_controller_tb.sv

// ==== tests/jump_controller_tb.sv ====
`timescale 1ns/1ps

module jump_controller_tb
	import bp_pkg::*;
	import rv_isa_pkg::*;
();

	localparam int unsigned CLK_PERIOD      = 40;
	localparam int unsigned RESET_CYCLES    = 16;
	localparam int unsigned DIRECTED_CYCLES = 32;
	localparam int unsigned N_RANDOM        = 2000;
	localparam int unsigned TOTAL_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + N_RANDOM + 100;
	localparam logic [31:0] NOP             = 32'h0000_0013;   // addi x0, x0, 0

	logic                 clk;
	logic                 rst_n_i;
	logic                 group_valid_i;
	logic [XLEN-1:0]      pc_0_i;
	logic [XLEN-1:0]      pc_1_i;
	logic [XLEN-1:0]      instr_0_i;
	logic [XLEN-1:0]      instr_1_i;
	logic                 upd_valid_i;
	logic                 upd_jalr_i;
	logic [XLEN-1:0]      upd_pc_i;
	logic                 upd_mispredict_i;
	logic [HIST_W-1:0]    upd_history_i;
	logic [XLEN-1:0]      upd_correct_pc_i;
	logic                 ras_restore_en_i;
	logic [RAS_PTR_W-1:0] ras_restore_tos_i;
	logic                 jump_0_o;
	logic                 jump_1_o;
	logic                 jalr_0_o;
	logic                 jalr_1_o;
	logic [HIST_W-1:0]    history_0_o;
	logic [HIST_W-1:0]    history_1_o;
	logic                 jalr_pred_valid_o;
	logic [XLEN-1:0]      jalr_target_o;
	logic [RAS_PTR_W-1:0] ras_tos_o;

	// Reference state
	logic [1:0]  ref_bht [32];
	logic [4:0]  ref_ghr;
	logic        ref_jtc_valid [32];
	logic [24:0] ref_jtc_tag [32];
	logic [31:0] ref_jtc_target [32];
	logic [31:0] ref_ras [8];
	logic [2:0]  ref_ptr;

	// Expected outputs and next-state helpers
	logic        exp_jump_0, exp_jump_1, exp_jalr_0, exp_jalr_1, exp_pred_valid;
	logic [5:0]  exp_hist_0, exp_hist_1;
	logic [31:0] exp_target;
	logic [2:0]  exp_tos;
	logic [4:0]  exp_ghr_spec;
	logic        exp_push, exp_pop;
	logic [31:0] exp_push_addr;

	logic [31:0] lfsr_state = 32'hb882_6017;
	int          error_count = 0;
	int          check_count = 0;
	logic [2:0]  saved_tos;

	jump_controller jump_controller_inst (.*);

	bind jump_controller jump_controller_assert assert_inst (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.group_valid_i     (group_valid_i),
		.instr_0_i         (instr_0_i),
		.jump_0_i          (jump_0_o),
		.jump_1_i          (jump_1_o),
		.jalr_0_i          (jalr_0_o),
		.jalr_1_i          (jalr_1_o),
		.jalr_pred_valid_i (jalr_pred_valid_o),
		.ras_restore_en_i  (ras_restore_en_i),
		.ras_restore_tos_i (ras_restore_tos_i),
		.ras_tos_i         (ras_tos_o)
	);

	//////////////////////////////
	// Clock, reset, watchdog
	//////////////////////////////

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		rst_n_i = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n_i <= 1'b1;
	end

	initial begin
		#(TOTAL_CYCLES * CLK_PERIOD);
		$display("ERROR: watchdog expired before the test sequence finished");
		$display("STATUS: FAIL");
		$fatal(1, "watchdog timeout");
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003)
				: (lfsr_state >> 1);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic logic [31:0] make_jal(input logic [4:0] rd);
		return {20'h00010, rd, OPC_JAL};
	endfunction

	function automatic logic [31:0] make_jalr(input logic [4:0] rd, input logic [4:0] rs1);
		return {12'h000, rs1, 3'b000, rd, OPC_JALR};
	endfunction

	function automatic logic [31:0] make_branch();
		return {7'h00, 5'd2, 5'd3, 3'b000, 5'h08, OPC_BRANCH};   // beq x3, x2
	endfunction

	function automatic logic [4:0] pick_reg();
		logic [1:0] sel;
		sel = 2'(rand_bits(2));
		case (sel)
			2'd0:    return 5'd0;
			2'd1:    return 5'd1;
			2'd2:    return 5'd5;
			default: return 5'd7;
		endcase
	endfunction

	function automatic logic [31:0] random_instr();
		logic [1:0] kind;
		logic [4:0] rd;
		logic [4:0] rs1;
		kind = 2'(rand_bits(2));
		rd   = pick_reg();
		rs1  = pick_reg();
		case (kind)
			2'd0:    return make_jal(rd);
			2'd1:    return make_jalr(rd, rs1);
			2'd2:    return make_branch();
			default: return NOP;
		endcase
	endfunction

	function automatic logic [31:0] random_pc();
		logic [9:0] word_idx;
		word_idx = 10'(rand_bits(10));
		return {20'h0, word_idx, 2'b00};   // Small space so cache entries get reused
	endfunction

	function automatic logic link_reg(input logic [4:0] r);
		return (r == 5'd1) || (r == 5'd5);
	endfunction

	// {jal, jalr, branch, call, return}
	function automatic logic [4:0] decode_slot(input logic [31:0] w);
		logic jal, jalr, br;
		jal  = w[6:0] == 7'b1101111;
		jalr = w[6:0] == 7'b1100111;
		br   = w[6:0] == 7'b1100011;
		return {jal, jalr, br, (jal | jalr) & link_reg(w[11:7]),
			jalr & link_reg(w[19:15]) & (w[11:7] == 5'd0)};
	endfunction

	//////////////////////////////
	// Reference model
	//////////////////////////////

	function automatic void ref_reset();
		ref_ghr = '0;
		ref_ptr = '0;
		for (int i = 0; i < 32; i++) begin
			ref_bht[i]       = 2'b01;
			ref_jtc_valid[i] = 1'b0;
			ref_jtc_tag[i]   = '0;
			ref_jtc_target[i] = '0;
		end
		for (int i = 0; i < 8; i++) begin
			ref_ras[i] = '0;
		end
	endfunction

	function automatic void ref_predict();
		logic [4:0]  d0, d1, ghr_1, idx;
		logic        t0, t1, live_0, live_1, sel, sel_ret;
		logic [31:0] sel_pc;
		logic [2:0]  top;
		d0     = decode_slot(instr_0_i);
		d1     = decode_slot(instr_1_i);
		live_0 = group_valid_i;
		idx    = pc_0_i[6:2] ^ ref_ghr;
		t0     = ref_bht[idx][1];
		ghr_1  = (live_0 && d0[2]) ? {ref_ghr[3:0], t0} : ref_ghr;
		idx    = pc_1_i[6:2] ^ ghr_1;
		t1     = ref_bht[idx][1];
		exp_jump_0 = d0[4] | (d0[2] & t0);
		exp_jump_1 = d1[4] | (d1[2] & t1);
		exp_jalr_0 = d0[3];
		exp_jalr_1 = d1[3];
		exp_hist_0 = {ref_ghr, t0};
		exp_hist_1 = {ghr_1, t1};
		live_1       = live_0 && !exp_jump_0 && !d0[3];   // Redirect kills slot 1
		exp_ghr_spec = (live_1 && d1[2]) ? {ghr_1[3:0], t1} : ghr_1;
		sel     = 1'b0;
		sel_ret = 1'b0;
		sel_pc  = pc_0_i;
		if (live_0 && d0[3]) begin
			sel     = 1'b1;
			sel_ret = d0[0];
		end else if (live_1 && d1[3]) begin
			sel     = 1'b1;
			sel_ret = d1[0];
			sel_pc  = pc_1_i;
		end
		top            = ref_ptr - 3'd1;
		exp_pred_valid = 1'b0;
		exp_target     = '0;
		if (sel && sel_ret) begin
			exp_pred_valid = 1'b1;
			exp_target     = ref_ras[top];
		end else if (sel && ref_jtc_valid[sel_pc[6:2]]
			&& ref_jtc_tag[sel_pc[6:2]] == sel_pc[31:7]) begin
			exp_pred_valid = 1'b1;
			exp_target     = ref_jtc_target[sel_pc[6:2]];
		end
		exp_push      = 1'b0;
		exp_pop       = 1'b0;
		exp_push_addr = pc_0_i + 32'd4;
		if (live_0 && (d0[1] || d0[0])) begin
			exp_push = d0[1];
			exp_pop  = d0[0];
		end else if (live_1 && (d1[1] || d1[0])) begin
			exp_push      = d1[1];
			exp_pop       = d1[0];
			exp_push_addr = pc_1_i + 32'd4;
		end
		exp_tos = ref_ptr;
	endfunction

	// State after the coming rising edge
	function automatic void ref_advance();
		logic [4:0] ughr, uidx;
		logic       actual, gs_upd;
		logic [2:0] top;
		top    = ref_ptr - 3'd1;
		gs_upd = upd_valid_i && !upd_jalr_i;
		ughr   = upd_history_i[5:1];
		actual = upd_history_i[0] ^ upd_mispredict_i;
		uidx   = upd_pc_i[6:2] ^ ughr;
		if (gs_upd && actual && ref_bht[uidx] != 2'b11) begin
			ref_bht[uidx] = ref_bht[uidx] + 2'd1;
		end else if (gs_upd && !actual && ref_bht[uidx] != 2'b00) begin
			ref_bht[uidx] = ref_bht[uidx] - 2'd1;
		end
		ref_ghr = (gs_upd && upd_mispredict_i) ? {ughr[3:0], actual} : exp_ghr_spec;
		if (upd_valid_i && upd_jalr_i && upd_mispredict_i) begin
			ref_jtc_valid[upd_pc_i[6:2]]  = 1'b1;
			ref_jtc_tag[upd_pc_i[6:2]]    = upd_pc_i[31:7];
			ref_jtc_target[upd_pc_i[6:2]] = upd_correct_pc_i;
		end
		if (ras_restore_en_i) begin
			ref_ptr = ras_restore_tos_i;
		end else if (exp_push && exp_pop) begin
			ref_ras[top] = exp_push_addr;
		end else if (exp_push) begin
			ref_ras[ref_ptr] = exp_push_addr;
			ref_ptr          = ref_ptr + 3'd1;
		end else if (exp_pop) begin
			ref_ptr = top;
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("FAILED %s: got 0x%0h expected 0x%0h", name, got, expected);
			$display("STATUS: FAIL");
			$fatal(1, "output mismatch");
		end
	endtask

	// Outputs are settled at the falling edge
	initial begin
		ref_reset();
		wait (rst_n_i === 1'b1);
		forever begin
			@(negedge clk);
			ref_predict();
			check_value("jump_0_o", jump_0_o, exp_jump_0);
			check_value("jump_1_o", jump_1_o, exp_jump_1);
			check_value("jalr_0_o", jalr_0_o, exp_jalr_0);
			check_value("jalr_1_o", jalr_1_o, exp_jalr_1);
			check_value("history_0_o", history_0_o, exp_hist_0);
			check_value("history_1_o", history_1_o, exp_hist_1);
			check_value("jalr_pred_valid_o", jalr_pred_valid_o, exp_pred_valid);
			check_value("jalr_target_o", jalr_target_o, exp_target);
			check_value("ras_tos_o", ras_tos_o, exp_tos);
			ref_advance();
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic send_group(input logic gv, input logic [31:0] p0, input logic [31:0] i0,
		input logic [31:0] i1);
		@(posedge clk);
		group_valid_i    <= gv;
		pc_0_i           <= p0;
		pc_1_i           <= p0 + 32'd4;
		instr_0_i        <= i0;
		instr_1_i        <= i1;
		upd_valid_i      <= 1'b0;
		ras_restore_en_i <= 1'b0;
	endtask

	task automatic send_update(input logic jalr, input logic [31:0] pc, input logic misp,
		input logic [5:0] hist, input logic [31:0] cpc);
		@(posedge clk);
		group_valid_i    <= 1'b0;
		upd_valid_i      <= 1'b1;
		upd_jalr_i       <= jalr;
		upd_pc_i         <= pc;
		upd_mispredict_i <= misp;
		upd_history_i    <= hist;
		upd_correct_pc_i <= cpc;
		ras_restore_en_i <= 1'b0;
	endtask

	task automatic send_restore(input logic [2:0] tos);
		@(posedge clk);
		group_valid_i     <= 1'b0;
		upd_valid_i       <= 1'b0;
		ras_restore_en_i  <= 1'b1;
		ras_restore_tos_i <= tos;
	endtask

	task automatic send_random_update();
		logic        jalr, misp;
		logic [5:0]  hist;
		logic [31:0] pc, cpc;
		jalr = 1'(rand_bits(1));
		misp = 1'(rand_bits(1));
		hist = 6'(rand_bits(6));
		pc   = random_pc();
		cpc  = rand_bits(32);
		send_update(jalr, pc, misp, hist, cpc);
	endtask

	initial begin
		logic [2:0] kind;
		// A live JALR during reset shows the target cache starts empty
		group_valid_i     = 1'b1;
		pc_0_i            = '0;
		pc_1_i            = '0;
		instr_0_i         = make_jalr(REG_ZERO, 5'd6);
		instr_1_i         = NOP;
		upd_valid_i       = 1'b0;
		upd_jalr_i        = 1'b0;
		upd_pc_i          = '0;
		upd_mispredict_i  = 1'b0;
		upd_history_i     = '0;
		upd_correct_pc_i  = '0;
		ras_restore_en_i  = 1'b0;
		ras_restore_tos_i = '0;
		wait (rst_n_i === 1'b1);

		// Decode and blocking
		send_group(1'b1, 32'h0100, make_jal(REG_ZERO), make_jal(REG_RA));
		send_group(1'b1, 32'h0108, make_jalr(REG_ZERO, 5'd6), make_branch());
		send_group(1'b1, 32'h0110, make_jalr(REG_ZERO, 5'd6), make_jalr(REG_ZERO, REG_RA));
		send_group(1'b0, 32'h0118, make_jal(REG_RA), NOP);    // Nothing pushed

		// Counter training at index 0x10 with zero history
		send_update(1'b0, 32'h2040, 1'b0, 6'b000000, '0);
		send_group(1'b1, 32'h2044, make_branch(), NOP);
		send_update(1'b0, 32'h2040, 1'b1, 6'b000000, '0);
		send_group(1'b1, 32'h2044, make_branch(), NOP);
		send_update(1'b0, 32'h2040, 1'b1, 6'b000000, '0);
		send_group(1'b1, 32'h2044, make_branch(), NOP);

		// Speculative history and repair
		send_group(1'b1, 32'h3000, make_branch(), make_branch());
		send_update(1'b0, 32'h3000, 1'b1, 6'b010100, '0);
		send_group(1'b1, 32'h3000, make_branch(), make_branch());

		// Nested call and return
		send_group(1'b1, 32'h4000, make_jal(REG_RA), NOP);
		send_group(1'b1, 32'h5000, NOP, make_jalr(REG_T0, 5'd7));
		send_group(1'b1, 32'h6000, make_jalr(REG_ZERO, REG_RA), NOP);
		send_group(1'b1, 32'h6100, make_jalr(REG_ZERO, REG_T0), NOP);

		// Target cache hit and then another tag at the same index
		send_update(1'b1, 32'h7010, 1'b1, 6'b000000, 32'h0000_9abc);
		send_group(1'b1, 32'h7010, make_jalr(REG_ZERO, 5'd6), NOP);
		send_group(1'b1, 32'h7090, make_jalr(REG_ZERO, 5'd6), NOP);

		// Checkpoint restore
		send_group(1'b1, 32'h8000, make_jal(REG_RA), NOP);
		send_group(1'b0, 32'h0000, NOP, NOP);
		saved_tos = ref_ptr;
		send_group(1'b1, 32'ha000, make_jal(REG_RA), NOP);
		send_group(1'b1, 32'hb000, make_jal(REG_T0), NOP);
		send_group(1'b1, 32'hc000, make_jalr(REG_ZERO, REG_RA), NOP);
		send_restore(saved_tos);
		send_group(1'b1, 32'hd000, make_jalr(REG_ZERO, REG_RA), NOP);   // Back to 0x8004

		for (int n = 0; n < N_RANDOM; n++) begin
			kind = 3'(rand_bits(3));
			if (kind == 3'd0) begin
				send_random_update();
			end else if (kind == 3'd1) begin
				send_restore(3'(rand_bits(3)));
			end else begin
				send_group(rand_bits(3) != 32'd0, random_pc(), random_instr(), random_instr());
			end
		end

		repeat (2) @(posedge clk);
		if (error_count == 0 && check_count > 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("ERROR: no outputs were compared or a check failed");
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== tests/jump_controller_assert.sv ====
`timescale 1ns/1ps

module jump_controller_assert
	import bp_pkg::*;
	import rv_isa_pkg::*;
(
	input logic                 clk,
	input logic                 rst_n_i,
	input logic                 group_valid_i,
	input logic [XLEN-1:0]      instr_0_i,
	input logic                 jump_0_i,
	input logic                 jump_1_i,
	input logic                 jalr_0_i,
	input logic                 jalr_1_i,
	input logic                 jalr_pred_valid_i,
	input logic                 ras_restore_en_i,
	input logic [RAS_PTR_W-1:0] ras_restore_tos_i,
	input logic [RAS_PTR_W-1:0] ras_tos_i
);

	logic slot0_quiet;     // Slot 0 neither calls nor returns
	logic slot1_blocked;

	function automatic logic link_reg(input logic [4:0] r);
		return (r == REG_RA) || (r == REG_T0);
	endfunction

	assign slot0_quiet = !link_reg(instr_0_i[11:7]) && !(jalr_0_i && link_reg(instr_0_i[19:15]));
	assign slot1_blocked = group_valid_i && (jump_0_i || jalr_0_i) && (jump_1_i || jalr_1_i)
		&& slot0_quiet && !ras_restore_en_i;

	a_no_pred_after_reset: assert property (@(posedge clk) $rose(rst_n_i) |-> !jalr_pred_valid_i)
		else $error("JALR prediction valid right after reset");

	a_blocked_slot_ras: assert property (@(posedge clk) disable iff (!rst_n_i)
		slot1_blocked |=> $stable(ras_tos_i))
		else $error("Blocked slot 1 moved the RAS pointer");

	a_restore_tos: assert property (@(posedge clk) disable iff (!rst_n_i)
		ras_restore_en_i |=> (ras_tos_i == $past(ras_restore_tos_i)))
		else $error("RAS pointer not restored");

endmodule

// ==== logic/jump_controller.sv ====
`timescale 1ns/1ps

module jump_controller
	import bp_pkg::*;
	import rv_isa_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 group_valid_i,
	input  logic [XLEN-1:0]      pc_0_i,
	input  logic [XLEN-1:0]      pc_1_i,
	input  logic [XLEN-1:0]      instr_0_i,
	input  logic [XLEN-1:0]      instr_1_i,
	// Resolve channel from the back end
	input  logic                 upd_valid_i,
	input  logic                 upd_jalr_i,
	input  logic [XLEN-1:0]      upd_pc_i,
	input  logic                 upd_mispredict_i,
	input  logic [HIST_W-1:0]    upd_history_i,
	input  logic [XLEN-1:0]      upd_correct_pc_i,
	input  logic                 ras_restore_en_i,
	input  logic [RAS_PTR_W-1:0] ras_restore_tos_i,
	output logic                 jump_0_o,
	output logic                 jump_1_o,
	output logic                 jalr_0_o,
	output logic                 jalr_1_o,
	output logic [HIST_W-1:0]    history_0_o,
	output logic [HIST_W-1:0]    history_1_o,
	output logic                 jalr_pred_valid_o,
	output logic [XLEN-1:0]      jalr_target_o,
	output logic [RAS_PTR_W-1:0] ras_tos_o
);

	rv_instr_u              instr [FETCH_WIDTH];
	logic [XLEN-1:0]        pc [FETCH_WIDTH];
	logic [XLEN-1:0]        link_addr [FETCH_WIDTH];
	logic [FETCH_WIDTH-1:0] is_jal;
	logic [FETCH_WIDTH-1:0] is_jalr;
	logic [FETCH_WIDTH-1:0] is_branch;
	logic [FETCH_WIDTH-1:0] is_call;
	logic [FETCH_WIDTH-1:0] is_return;
	logic [FETCH_WIDTH-1:0] taken;
	logic [FETCH_WIDTH-1:0] jump;
	logic [FETCH_WIDTH-1:0] live;

	function automatic logic is_link(input logic [4:0] r);
		return (r == REG_RA) || (r == REG_T0);
	endfunction

	assign instr[0] = instr_0_i;
	assign instr[1] = instr_1_i;
	assign pc[0]    = pc_0_i;
	assign pc[1]    = pc_1_i;

	//////////////////////////////
	// Slot decode
	//////////////////////////////

	for (genvar k = 0; k < FETCH_WIDTH; k++) begin : g_slot
		assign is_jal[k]    = instr[k].j_fmt.opcode == OPC_JAL;
		assign is_jalr[k]   = instr[k].i_fmt.opcode == OPC_JALR;
		assign is_branch[k] = instr[k].i_fmt.opcode == OPC_BRANCH;
		assign is_call[k]   = (is_jal[k] | is_jalr[k]) & is_link(instr[k].j_fmt.rd);
		assign is_return[k] = is_jalr[k] & is_link(instr[k].i_fmt.rs1)
			& (instr[k].i_fmt.rd == REG_ZERO);
		assign jump[k]      = is_jal[k] | (is_branch[k] & taken[k]);
		assign link_addr[k] = pc[k] + XLEN'(4);
	end

	// Anything that redirects kills the slots behind it
	assign live[0] = group_valid_i;
	assign live[1] = live[0] & ~jump[0] & ~is_jalr[0];

	assign jump_0_o = jump[0];
	assign jump_1_o = jump[1];
	assign jalr_0_o = is_jalr[0];
	assign jalr_1_o = is_jalr[1];

	//////////////////////////////
	// Predictors
	//////////////////////////////

	bp_update_if upd_bus ();

	assign upd_bus.valid      = upd_valid_i;
	assign upd_bus.jalr       = upd_jalr_i;
	assign upd_bus.pc         = upd_pc_i;
	assign upd_bus.mispredict = upd_mispredict_i;
	assign upd_bus.history    = upd_history_i;
	assign upd_bus.correct_pc = upd_correct_pc_i;

	gshare_predictor gshare_inst (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.is_branch_0_i (is_branch[0]),
		.is_branch_1_i (is_branch[1]),
		.live_0_i      (live[0]),
		.live_1_i      (live[1]),
		.pc_0_i        (pc_0_i),
		.pc_1_i        (pc_1_i),
		.upd           (upd_bus),
		.taken_0_o     (taken[0]),
		.taken_1_o     (taken[1]),
		.history_0_o   (history_0_o),
		.history_1_o   (history_1_o)
	);

	jalr_predictor jalr_inst (
		.clk               (clk),
		.rst_n_i           (rst_n_i),
		.is_jalr_0_i       (is_jalr[0]),
		.is_jalr_1_i       (is_jalr[1]),
		.is_call_0_i       (is_call[0]),
		.is_call_1_i       (is_call[1]),
		.is_return_0_i     (is_return[0]),
		.is_return_1_i     (is_return[1]),
		.live_0_i          (live[0]),
		.live_1_i          (live[1]),
		.link_addr_0_i     (link_addr[0]),
		.link_addr_1_i     (link_addr[1]),
		.pc_0_i            (pc_0_i),
		.pc_1_i            (pc_1_i),
		.upd               (upd_bus),
		.ras_restore_en_i  (ras_restore_en_i),
		.ras_restore_tos_i (ras_restore_tos_i),
		.pred_valid_o      (jalr_pred_valid_o),
		.target_o          (jalr_target_o),
		.ras_tos_o         (ras_tos_o)
	);

endmodule

// ==== logic/jalr_predictor.sv ====
`timescale 1ns/1ps

module jalr_predictor
	import bp_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst_n_i,
	input  logic                 is_jalr_0_i,
	input  logic                 is_jalr_1_i,
	input  logic                 is_call_0_i,
	input  logic                 is_call_1_i,
	input  logic                 is_return_0_i,
	input  logic                 is_return_1_i,
	input  logic                 live_0_i,
	input  logic                 live_1_i,
	input  logic [XLEN-1:0]      link_addr_0_i,
	input  logic [XLEN-1:0]      link_addr_1_i,
	input  logic [XLEN-1:0]      pc_0_i,
	input  logic [XLEN-1:0]      pc_1_i,
	bp_update_if.dst             upd,
	input  logic                 ras_restore_en_i,
	input  logic [RAS_PTR_W-1:0] ras_restore_tos_i,
	output logic                 pred_valid_o,
	output logic [XLEN-1:0]      target_o,
	output logic [RAS_PTR_W-1:0] ras_tos_o
);

	logic                 jtc_valid_q [JTC_ENTRIES];
	logic [JTC_TAG_W-1:0] jtc_tag_q [JTC_ENTRIES];
	logic [XLEN-1:0]      jtc_target_q [JTC_ENTRIES];
	logic [XLEN-1:0]      ras_q [RAS_DEPTH];
	logic [RAS_PTR_W-1:0] ras_ptr_q;
	logic [RAS_PTR_W-1:0] ras_top;       // Last pushed entry
	logic                 sel_jalr;
	logic                 sel_return;
	logic [XLEN-1:0]      sel_pc;
	logic [JTC_IDX_W-1:0] lkp_idx;
	logic                 lkp_hit;
	logic                 do_push;
	logic                 do_pop;
	logic [XLEN-1:0]      push_addr;
	logic                 jtc_wr;
	logic [JTC_IDX_W-1:0] wr_idx;

	//////////////////////////////
	// Lookup
	//////////////////////////////

	// First live JALR in the group
	always_comb begin
		sel_jalr   = 1'b0;
		sel_return = 1'b0;
		sel_pc     = pc_0_i;
		if (live_0_i && is_jalr_0_i) begin
			sel_jalr   = 1'b1;
			sel_return = is_return_0_i;
		end else if (live_1_i && is_jalr_1_i) begin
			sel_jalr   = 1'b1;
			sel_return = is_return_1_i;
			sel_pc     = pc_1_i;
		end
	end

	assign lkp_idx = sel_pc[JTC_IDX_W+1:2];
	assign lkp_hit = jtc_valid_q[lkp_idx]
		&& (jtc_tag_q[lkp_idx] == sel_pc[XLEN-1:JTC_IDX_W+2]);
	assign ras_top = ras_ptr_q - RAS_PTR_W'(1);

	always_comb begin
		pred_valid_o = 1'b0;
		target_o     = '0;
		if (sel_jalr && sel_return) begin
			pred_valid_o = 1'b1;
			target_o     = ras_q[ras_top];
		end else if (sel_jalr && lkp_hit) begin
			pred_valid_o = 1'b1;
			target_o     = jtc_target_q[lkp_idx];
		end
	end

	//////////////////////////////
	// Return address stack
	//////////////////////////////

	// Any call or return ends the group, so one slot acts at most
	always_comb begin
		do_push   = 1'b0;
		do_pop    = 1'b0;
		push_addr = link_addr_0_i;
		if (live_0_i && (is_call_0_i || is_return_0_i)) begin
			do_push = is_call_0_i;
			do_pop  = is_return_0_i;
		end else if (live_1_i && (is_call_1_i || is_return_1_i)) begin
			do_push   = is_call_1_i;
			do_pop    = is_return_1_i;
			push_addr = link_addr_1_i;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ras_ptr_q <= '0;
			for (int i = 0; i < RAS_DEPTH; i++) begin
				ras_q[i] <= '0;
			end
		end else if (ras_restore_en_i) begin
			ras_ptr_q <= ras_restore_tos_i;         // Checkpoint restore
		end else if (do_pop && do_push) begin
			ras_q[ras_top] <= push_addr;            // Pop then push, pointer stays
		end else if (do_push) begin
			ras_q[ras_ptr_q] <= push_addr;
			ras_ptr_q        <= ras_ptr_q + RAS_PTR_W'(1);
		end else if (do_pop) begin
			ras_ptr_q <= ras_top;
		end
	end

	assign ras_tos_o = ras_ptr_q;

	//////////////////////////////
	// Target cache training
	//////////////////////////////

	assign jtc_wr = upd.valid & upd.jalr & upd.mispredict;
	assign wr_idx = upd.pc[JTC_IDX_W+1:2];

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < JTC_ENTRIES; i++) begin
				jtc_valid_q[i] <= 1'b0;
			end
		end else if (jtc_wr) begin
			jtc_valid_q[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (jtc_wr) begin
			jtc_tag_q[wr_idx]    <= upd.pc[XLEN-1:JTC_IDX_W+2];
			jtc_target_q[wr_idx] <= upd.correct_pc;
		end
	end

endmodule

// ==== logic/gshare_predictor.sv ====
`timescale 1ns/1ps

module gshare_predictor
	import bp_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n_i,
	input  logic              is_branch_0_i,
	input  logic              is_branch_1_i,
	input  logic              live_0_i,
	input  logic              live_1_i,
	input  logic [XLEN-1:0]   pc_0_i,
	input  logic [XLEN-1:0]   pc_1_i,
	bp_update_if.dst          upd,
	output logic              taken_0_o,
	output logic              taken_1_o,
	output logic [HIST_W-1:0] history_0_o,
	output logic [HIST_W-1:0] history_1_o
);

	logic [1:0]           bht_q [BHT_ENTRIES];
	logic [GHR_W-1:0]     ghr_q;
	logic [GHR_W-1:0]     ghr_1;          // Seen by slot 1
	logic [GHR_W-1:0]     ghr_spec;       // After the whole group
	logic [BHT_IDX_W-1:0] idx_0;
	logic [BHT_IDX_W-1:0] idx_1;
	logic                 upd_en;
	logic                 upd_actual;
	logic [GHR_W-1:0]     upd_ghr;
	logic [BHT_IDX_W-1:0] upd_idx;
	logic [1:0]           upd_cnt;
	logic [1:0]           upd_cnt_next;

	//////////////////////////////
	// Lookup
	//////////////////////////////

	assign idx_0       = pc_0_i[BHT_IDX_W+1:2] ^ ghr_q;
	assign taken_0_o   = bht_q[idx_0][1];
	assign history_0_o = {ghr_q, taken_0_o};

	// Slot 0's guess is already in the history slot 1 indexes with
	assign ghr_1 = (live_0_i && is_branch_0_i) ? {ghr_q[GHR_W-2:0], taken_0_o} : ghr_q;

	assign idx_1       = pc_1_i[BHT_IDX_W+1:2] ^ ghr_1;
	assign taken_1_o   = bht_q[idx_1][1];
	assign history_1_o = {ghr_1, taken_1_o};

	assign ghr_spec = (live_1_i && is_branch_1_i) ? {ghr_1[GHR_W-2:0], taken_1_o} : ghr_1;

	//////////////////////////////
	// Training
	//////////////////////////////

	assign upd_en     = upd.valid & ~upd.jalr;
	assign upd_ghr    = upd.history[HIST_W-1:1];
	assign upd_actual = upd.history[0] ^ upd.mispredict;   // Flip the guess on a miss
	assign upd_idx    = upd.pc[BHT_IDX_W+1:2] ^ upd_ghr;
	assign upd_cnt    = bht_q[upd_idx];

	// Saturating 2-bit counter
	always_comb begin
		upd_cnt_next = upd_cnt;
		if (upd_actual && (upd_cnt != 2'b11)) begin
			upd_cnt_next = upd_cnt + 2'd1;
		end else if (!upd_actual && (upd_cnt != 2'b00)) begin
			upd_cnt_next = upd_cnt - 2'd1;
		end
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ghr_q <= '0;
			for (int i = 0; i < BHT_ENTRIES; i++) begin
				bht_q[i] <= 2'b01;     // Weakly not taken
			end
		end else begin
			if (upd_en) begin
				bht_q[upd_idx] <= upd_cnt_next;
			end
			// Repair beats the speculative shift
			if (upd_en && upd.mispredict) begin
				ghr_q <= {upd_ghr[GHR_W-2:0], upd_actual};
			end else begin
				ghr_q <= ghr_spec;
			end
		end
	end

endmodule

// ==== logic/bp_update_if.sv ====
`timescale 1ns/1ps

interface bp_update_if
	import bp_pkg::*;
();

	logic              valid;
	logic              jalr;         // Selects which predictor trains
	logic [XLEN-1:0]   pc;
	logic              mispredict;
	logic [HIST_W-1:0] history;      // Snapshot taken at prediction time
	logic [XLEN-1:0]   correct_pc;

	modport src (
		output valid, jalr, pc, mispredict, history, correct_pc
	);

	modport dst (
		input valid, jalr, pc, mispredict, history, correct_pc
	);

endinterface

// ==== logic/rv_isa_pkg.sv ====
package rv_isa_pkg;

	// Control transfer opcodes
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;

	// Registers that matter for call/return hints
	localparam logic [4:0] REG_ZERO = 5'd0;
	localparam logic [4:0] REG_RA   = 5'd1;
	localparam logic [4:0] REG_T0   = 5'd5;   // Alternate link register

	//////////////////////////////
	// Instruction views
	//////////////////////////////

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_i_fmt_t;

	typedef struct packed {
		logic [19:0] imm;      // Scrambled J immediate
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_j_fmt_t;

	// rd and opcode line up in both views
	typedef union packed {
		rv_i_fmt_t i_fmt;
		rv_j_fmt_t j_fmt;
	} rv_instr_u;

endpackage

// ==== logic/bp_pkg.sv ====
package bp_pkg;

	//////////////////////////////
	// Datapath
	//////////////////////////////

	localparam int unsigned XLEN        = 32;
	localparam int unsigned FETCH_WIDTH = 2;   // Slots per fetch group

	//////////////////////////////
	// Gshare
	//////////////////////////////

	localparam int unsigned BHT_ENTRIES = 32;
	localparam int unsigned BHT_IDX_W   = 5;
	localparam int unsigned GHR_W       = BHT_IDX_W;
	// Snapshot is {ghr, prediction}
	localparam int unsigned HIST_W      = GHR_W + 1;

	//////////////////////////////
	// Indirect jumps
	//////////////////////////////

	localparam int unsigned JTC_ENTRIES = 32;
	localparam int unsigned JTC_IDX_W   = 5;
	localparam int unsigned JTC_TAG_W   = XLEN - JTC_IDX_W - 2;   // PC above index bits
	localparam int unsigned RAS_DEPTH   = 8;
	localparam int unsigned RAS_PTR_W   = 3;

endpackage
